// File: include/posit_div_defs.svh
////////////////////
// Posit divider widths
////////////////////

`ifndef POSIT_DIV_DEFS_SVH
`define POSIT_DIV_DEFS_SVH

// Posit format
`define POSIT_N  16
`define POSIT_ES 1
`define POSIT_FW 15                  // N - ES fraction bits below the hidden one
`define POSIT_SW 7                   // Signed scale, wide enough for a difference

// Reciprocal seed table
`define SEED_AW 8
`define SEED_W  9                    // One integer bit

// Refinement depth, 0 to 2 stages
`define NR_ITER 1
`define DIV_LATENCY (`NR_ITER + 2)

`endif

// File: src/posit_div_pkg.sv
////////////////////
// Posit divider types
////////////////////

`include "posit_div_defs.svh"

package posit_div_pkg;

	typedef logic [`POSIT_N-1:0] posit_t;

	// One decoded operand
	typedef struct packed {
		logic                        sign;
		logic                        is_zero;
		logic                        is_nar;
		logic signed [`POSIT_SW-1:0] scale;   // regime * 2^es + exponent
		logic [`POSIT_FW:0]          mant;    // 1.FW, hidden one on top
	} operand_t;

	// Word carried down the pipeline
	typedef struct packed {
		logic                        valid;
		logic                        sign;
		logic                        res_nar;
		logic                        res_zero;
		logic signed [`POSIT_SW-1:0] scale;   // Dividend minus divisor scale
		logic [`POSIT_FW:0]          mant_a;
		logic [`POSIT_FW:0]          mant_b;
		logic [`POSIT_FW+1:0]        recip;   // 1.(FW+1) estimate of 1/mant_b
	} div_stage_t;

	////////////////////
	// Seed rule
	////////////////////

	// Rounded 1 / (1 + addr / 2^AW) with SEED_W-1 fraction bits
	function automatic logic [`SEED_W-1:0] seed_value(input int addr);
		int den;
		int num;
		int quo;
		den = (1 << `SEED_AW) + addr;
		num = 1 << (`SEED_W + `SEED_AW);   // Twice the scaled one, for rounding
		quo = (num + den) / (2 * den);
		return `SEED_W'(quo);
	endfunction

endpackage

// File: src/posit_div_decode.sv
////////////////////
// Operand decode stage
////////////////////

`include "posit_div_defs.svh"

module posit_div_decode (
	input  logic                       clk_i,
	input  logic                       reset_i,
	input  logic                       start_i,
	input  posit_div_pkg::posit_t      a_i,
	input  posit_div_pkg::posit_t      b_i,
	output posit_div_pkg::div_stage_t  stage_o
);

	localparam int N  = `POSIT_N;
	localparam int ES = `POSIT_ES;

	posit_div_pkg::operand_t   op_a, op_b;
	posit_div_pkg::div_stage_t stage_d;
	logic [`SEED_AW-1:0]       seed_addr;
	logic [`SEED_W-1:0]        seed_rom [2**`SEED_AW];

	// Split a posit into sign, scale and 1.f mantissa
	function automatic posit_div_pkg::operand_t decode_operand(input posit_div_pkg::posit_t p);
		posit_div_pkg::operand_t op;
		logic [N-1:0]  xa;
		logic [N-1:0]  body;
		logic [ES-1:0] e;
		logic          rc;
		logic          run;
		int            m;
		int            r;
		op.sign    = p[N-1];
		op.is_zero = (p == '0);
		op.is_nar  = (p == {1'b1, {(N-1){1'b0}}});
		xa  = p[N-1] ? -p : p;
		rc  = xa[N-2];
		m   = 1;
		run = 1'b1;
		for (int i = N - 3; i >= 0; i--) begin   // Regime run length
			if (run && xa[i] == rc)
				m++;
			else
				run = 1'b0;
		end
		r    = rc ? m - 1 : -m;
		body = {xa[N-3:0], 2'b00} << m;          // Drop the rest of the run and its terminator
		e    = body[N-1 -: ES];
		op.scale = `POSIT_SW'(r * (1 << ES) + int'(e));
		op.mant  = {1'b1, body[N-ES-1:0]};
		return op;
	endfunction

	assign op_a = decode_operand(a_i);
	assign op_b = decode_operand(b_i);

	// Seed table, built from the package rule
	for (genvar g = 0; g < 2**`SEED_AW; g++) begin : g_seed
		assign seed_rom[g] = posit_div_pkg::seed_value(g);
	end

	assign seed_addr = op_b.mant[`POSIT_FW-1 -: `SEED_AW];

	always_comb begin
		stage_d.valid    = start_i;
		stage_d.sign     = op_a.sign ^ op_b.sign;
		stage_d.res_nar  = op_b.is_zero | op_a.is_nar;
		stage_d.res_zero = ~stage_d.res_nar & (op_a.is_zero | op_b.is_nar);
		stage_d.scale    = op_a.scale - op_b.scale;
		stage_d.mant_a   = op_a.mant;
		stage_d.mant_b   = op_b.mant;
		// Entry 0 is exactly 1.0, so a power-of-two divisor stays exact
		stage_d.recip    = {seed_rom[seed_addr], {(`POSIT_FW+2-`SEED_W){1'b0}}};
	end

	always_ff @(posedge clk_i) begin
		if (start_i)
			stage_o <= stage_d;
		if (reset_i)
			stage_o.valid <= 1'b0;
		else
			stage_o.valid <= start_i;
	end

endmodule

// File: src/posit_div_nr_stage.sv
////////////////////
// Newton-Raphson step
////////////////////

`include "posit_div_defs.svh"

module posit_div_nr_stage (
	input  logic                       clk_i,
	input  logic                       reset_i,
	input  posit_div_pkg::div_stage_t  stage_i,
	output posit_div_pkg::div_stage_t  stage_o
);

	localparam int RW = `POSIT_FW + 2;        // recip width, 1.16
	localparam int PW = 2 * `POSIT_FW + 3;    // recip * mant_b, 2.31

	logic [PW-1:0]             rb;
	logic [PW-1:0]             two_minus;
	logic [RW:0]               corr;          // 2 - r*b cut to 2.16
	logic [2*RW:0]             refined;       // 3.32
	posit_div_pkg::div_stage_t stage_d;

	// r' = r * (2 - r * b)
	always_comb begin
		rb        = stage_i.recip * stage_i.mant_b;
		two_minus = {1'b1, {(PW-1){1'b0}}} - rb;
		corr      = two_minus[PW-1 -: RW+1];
		refined   = stage_i.recip * corr;
		stage_d       = stage_i;
		stage_d.recip = refined[2*RW-2 -: RW];   // Back to 1.16, truncated
	end

	always_ff @(posedge clk_i) begin
		if (stage_i.valid)
			stage_o <= stage_d;
		if (reset_i)
			stage_o.valid <= 1'b0;
		else
			stage_o.valid <= stage_i.valid;
	end

endmodule

// File: src/posit_div_pack.sv
////////////////////
// Quotient pack stage
////////////////////

`include "posit_div_defs.svh"

module posit_div_pack (
	input  logic                       clk_i,
	input  logic                       reset_i,
	input  posit_div_pkg::div_stage_t  stage_i,
	output posit_div_pkg::posit_t      quot_o,
	output logic                       inf_o,
	output logic                       zero_o,
	output logic                       done_o
);

	localparam int N   = `POSIT_N;
	localparam int ES  = `POSIT_ES;
	localparam int FRW = 2 * `POSIT_FW + 1;   // Fraction bits of the product
	localparam int XW  = 2 + ES + FRW + N;    // Regime, exponent, fraction and spare

	logic [FRW+1:0]               prod;       // 2.31
	logic [FRW-1:0]               norm;
	logic signed [`POSIT_SW-1:0]  scale_n;
	logic signed [`POSIT_SW-1:0]  regime;
	logic [`POSIT_SW-1:0]         shamt;
	logic [ES-1:0]                exp_bits;
	logic                         neg, sat_hi, sat_lo;
	logic signed [XW-1:0]         packed_w;
	logic signed [XW-1:0]         shifted;
	logic [N-2:0]                 body, body_rnd, mag;
	logic                         guard, sticky, round_up;
	posit_div_pkg::posit_t        quot_d;

	always_comb begin
		prod    = stage_i.mant_a * stage_i.recip;
		// Below 1.0 means one more bit of left shift
		norm    = prod[FRW] ? prod[FRW-1:0] : {prod[FRW-2:0], 1'b0};
		scale_n = stage_i.scale - {{(`POSIT_SW-1){1'b0}}, ~prod[FRW]};

		regime   = scale_n >>> ES;
		exp_bits = scale_n[ES-1:0];
		neg      = scale_n[`POSIT_SW-1];
		sat_hi   = !neg && regime >= N - 2;
		sat_lo   = regime < -(N - 2);
		shamt    = neg ? ~regime : regime;   // Run length minus one

		////////////////////
		// Regime insert and RNE
		////////////////////
		packed_w = {~neg, neg, exp_bits, norm, {N{1'b0}}};
		shifted  = packed_w >>> shamt;       // Sign fill extends the run
		body     = shifted[XW-1 -: N-1];
		guard    = shifted[XW-N];
		sticky   = |shifted[XW-N-1:0];
		round_up = guard & (body[0] | sticky);
		body_rnd = body + {{(N-2){1'b0}}, round_up};

		// Never round to zero or NaR
		if (sat_hi)
			mag = '1;
		else if (sat_lo)
			mag = {{(N-2){1'b0}}, 1'b1};
		else
			mag = body_rnd;

		if (stage_i.res_nar)
			quot_d = {1'b1, {(N-1){1'b0}}};
		else if (stage_i.res_zero)
			quot_d = '0;
		else
			quot_d = stage_i.sign ? -{1'b0, mag} : {1'b0, mag};
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			quot_o <= '0;
			inf_o  <= 1'b0;
			zero_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			done_o <= stage_i.valid;
			inf_o  <= stage_i.valid & stage_i.res_nar;
			zero_o <= stage_i.valid & stage_i.res_zero;
			if (stage_i.valid)
				quot_o <= quot_d;           // Held until the next result
		end
	end

endmodule

// File: src/posit_div_top.sv
////////////////////
// Posit divider top
////////////////////

`include "posit_div_defs.svh"

module posit_div_top (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic                  start_i,
	input  posit_div_pkg::posit_t a_i,
	input  posit_div_pkg::posit_t b_i,
	output posit_div_pkg::posit_t quot_o,
	output logic                  inf_o,
	output logic                  zero_o,
	output logic                  done_o
);

	// Entry 0 from decode, last entry into pack
	posit_div_pkg::div_stage_t stage [`NR_ITER+1];

	posit_div_decode u_decode (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.start_i (start_i),
		.a_i     (a_i),
		.b_i     (b_i),
		.stage_o (stage[0])
	);

	for (genvar i = 0; i < `NR_ITER; i++) begin : g_nr
		posit_div_nr_stage u_nr (
			.clk_i   (clk_i),
			.reset_i (reset_i),
			.stage_i (stage[i]),
			.stage_o (stage[i+1])
		);
	end

	posit_div_pack u_pack (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.stage_i (stage[`NR_ITER]),
		.quot_o  (quot_o),
		.inf_o   (inf_o),
		.zero_o  (zero_o),
		.done_o  (done_o)
	);

endmodule

// File: dv/posit_div_properties.sv
////////////////////
// Divider timing checks
////////////////////

`include "posit_div_defs.svh"

module posit_div_properties (
	input logic                  clk_i,
	input logic                  reset_i,
	input logic                  start_i,
	input posit_div_pkg::posit_t quot_o,
	input logic                  inf_o,
	input logic                  zero_o,
	input logic                  done_o
);
	timeunit 1ns;
	timeprecision 1ps;

	done_follows_start: assert property (@(posedge clk_i) disable iff (reset_i)
		done_o == $past(start_i, `DIV_LATENCY))
		else $error("done_o does not follow start_i by the pipeline latency");

	nar_on_inf: assert property (@(posedge clk_i) disable iff (reset_i)
		inf_o |-> quot_o == {1'b1, {(`POSIT_N-1){1'b0}}})
		else $error("inf_o high without the NaR pattern on quot_o");

	zero_on_zero: assert property (@(posedge clk_i) disable iff (reset_i)
		zero_o |-> quot_o == '0)
		else $error("zero_o high with a nonzero quot_o");

	quiet_in_reset: assert property (@(posedge clk_i) reset_i |=> !done_o)
		else $error("done_o high during reset");

endmodule

// File: dv/posit_div_tb.sv
////////////////////
// Posit divider testbench
////////////////////

`include "posit_div_defs.svh"

module posit_div_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 10;
	localparam int N_BURST      = 200;
	localparam int N_EXACT      = 200;
	localparam int N_SIGN       = 200;
	localparam int N_GENERAL    = 2000;
	localparam int N_OPS        = 1 + N_BURST + 6 + N_EXACT + 2 + 2 * N_SIGN + N_GENERAL + 6;
	localparam int IDLE_CYCLES  = RESET_CYCLES + 2 * `DIV_LATENCY + 8;   // Reset and gaps
	localparam int WATCHDOG_NS  = (N_OPS + `DIV_LATENCY + 20 + IDLE_CYCLES) * CLK_PERIOD;

	typedef struct packed {
		logic               sign;
		logic signed [15:0] scale;
		logic [16:0]        mant;      // 1.16
	} value_t;

	typedef struct packed {
		logic [15:0] quot;
		logic        inf;
		logic        zero;
		logic        near;             // One pattern step allowed
		logic        negated;          // Negation of the previous result
		logic [31:0] cycle;            // Edge that sampled start
	} expect_t;

	logic                  clk, reset, start;
	posit_div_pkg::posit_t div_a, div_b, quot;
	logic                  inf, zero, done;
	logic [31:0]           rng_state;
	logic [31:0]           cycle;
	posit_div_pkg::posit_t last_quot;
	expect_t               exp_q [$];

	posit_div_top i_dut (
		.clk_i   (clk),
		.reset_i (reset),
		.start_i (start),
		.a_i     (div_a),
		.b_i     (div_b),
		.quot_o  (quot),
		.inf_o   (inf),
		.zero_o  (zero),
		.done_o  (done)
	);

	bind posit_div_top posit_div_properties i_props (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.start_i (start_i),
		.quot_o  (quot_o),
		.inf_o   (inf_o),
		.zero_o  (zero_o),
		.done_o  (done_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Any posit except zero and NaR
	function automatic logic [15:0] random_operand();
		logic [31:0] r;
		r = next_random();
		while (r[15:0] == 16'h0000 || r[15:0] == 16'h8000)
			r = next_random();
		return r[15:0];
	endfunction

	////////////////////
	// Reference model
	////////////////////

	function automatic value_t posit_to_value(input logic [15:0] p);
		value_t      v;
		logic [15:0] x;
		logic        rc;
		int          i;
		int          m;
		int          k;
		int          e;
		int          fb;
		v.sign = p[15];
		x  = p[15] ? -p : p;
		rc = x[14];
		i  = 14;
		m  = 0;
		while (i >= 0 && x[i] == rc) begin
			m++;
			i--;
		end
		i--;                              // Terminator bit
		k = rc ? m - 1 : -m;
		e = 0;
		if (i >= 0) begin
			e = int'(x[i]);
			i--;
		end
		fb = (i + 1 < 0) ? 0 : i + 1;
		v.scale = 16'(2 * k + e);
		v.mant  = 17'h10000 | 17'((x & 16'((1 << fb) - 1)) << (16 - fb));
		return v;
	endfunction

	// Round the bit string regime, exponent, fraction, sticky to nearest even
	function automatic logic [15:0] value_to_posit(input logic sign, input int scale,
			input logic [39:0] frac, input logic sticky);
		logic [63:0] bits;
		logic [14:0] body;
		logic [15:0] mag;
		logic        guard;
		logic        rest;
		int          r;
		int          len;
		r = scale >>> 1;
		if (r >= 14)
			mag = 16'h7fff;
		else if (r < -14)
			mag = 16'h0001;
		else begin
			if (r >= 0) begin
				bits = ((64'd1 << (r + 1)) - 64'd1) << 1;
				len  = r + 2;
			end else begin
				bits = 64'd1;
				len  = 1 - r;
			end
			bits  = (bits << 41) | (64'(scale & 1) << 40) | 64'(frac);
			len   = len + 41;
			body  = 15'(bits >> (len - 15));
			guard = bits[len - 16];
			rest  = sticky || ((bits & ((64'd1 << (len - 16)) - 64'd1)) != 64'd0);
			body  = body + 15'(guard && (body[0] || rest));
			mag   = {1'b0, body};
		end
		return sign ? -mag : mag;
	endfunction

	function automatic expect_t model_divide(input logic [15:0] a, input logic [15:0] b);
		expect_t     ex;
		value_t      va, vb;
		logic [63:0] num, q, rem;
		int          s;
		ex = '0;
		if (b == 16'h0000 || a == 16'h8000) begin
			ex.quot = 16'h8000;
			ex.inf  = 1'b1;
		end else if (a == 16'h0000 || b == 16'h8000)
			ex.zero = 1'b1;
		else begin
			va = posit_to_value(a);
			vb = posit_to_value(b);
			s  = int'(va.scale) - int'(vb.scale);
			if (va.mant < vb.mant) begin
				num = 64'(va.mant) << 41;
				s--;
			end else
				num = 64'(va.mant) << 40;
			q   = num / 64'(vb.mant);       // 1.40 quotient
			rem = num % 64'(vb.mant);
			ex.quot = value_to_posit(va.sign ^ vb.sign, s, q[39:0], rem != 64'd0);
		end
		return ex;
	endfunction

	task automatic compare(input logic [31:0] got, input logic [31:0] expected,
			input string what);
		if (got !== expected) begin
			$display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, expected);
			$display("Simulation FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic issue(input logic [15:0] a, input logic [15:0] b, input logic near,
			input logic negated);
		expect_t ex;
		ex = model_divide(a, b);
		ex.near    = near;
		ex.negated = negated;
		@(posedge clk);
		ex.cycle = cycle + 1;
		start <= 1'b1;
		div_a <= a;
		div_b <= b;
		exp_q.push_back(ex);
	endtask

	task automatic idle();
		@(posedge clk);
		start <= 1'b0;
	endtask

	always @(posedge clk) begin : check_results
		expect_t     ex;
		logic [15:0] neg_last;
		int          diff;
		if (!reset && done) begin
			if (exp_q.size() == 0) begin
				$display("done_o rose with no division outstanding at %0t ns", $time);
				$display("Simulation FAILED");
				$fatal(1, "unexpected done_o");
			end else begin
				ex = exp_q.pop_front();
				neg_last = -last_quot;
				diff = int'($signed(quot)) - int'($signed(ex.quot));
				compare(cycle - ex.cycle, 32'(`DIV_LATENCY), "latency from start to done");
				compare(32'(inf), 32'(ex.inf), "inf flag");
				compare(32'(zero), 32'(ex.zero), "zero flag");
				if (ex.negated)
					compare(32'(quot), 32'(neg_last), "negated dividend quotient");
				if (ex.near)
					compare(32'(diff >= -1 && diff <= 1), 32'd1,
						$sformatf("quotient %h not within one of %h", quot, ex.quot));
				else
					compare(32'(quot), 32'(ex.quot), "exact quotient");
				last_quot <= quot;
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired before all divisions completed");
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	end

	initial begin : main_sequence
		logic [31:0]           r;
		posit_div_pkg::posit_t op_a, op_b;
		int                    s;
		clk       = 1'b0;
		reset     = 1'b1;
		start     = 1'b0;
		div_a     = '0;
		div_b     = '0;
		cycle     = '0;
		last_quot = '0;
		rng_state = 32'd16;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		compare(32'(done), 32'd0, "done_o after reset");

		// Lone start, then a back-to-back burst of any patterns
		issue(random_operand(), random_operand(), 1'b1, 1'b0);
		idle();
		while (exp_q.size() != 0) @(posedge clk);
		for (int i = 0; i < N_BURST; i++) begin
			r = next_random();
			issue(r[15:0], r[31:16], 1'b1, 1'b0);
		end

		////////////////////
		// Special cases
		////////////////////
		issue(random_operand(), 16'h0000, 1'b0, 1'b0);
		issue(16'h8000, random_operand(), 1'b0, 1'b0);
		issue(16'h8000, 16'h0000, 1'b0, 1'b0);
		issue(16'h0000, random_operand(), 1'b0, 1'b0);
		issue(random_operand(), 16'h8000, 1'b0, 1'b0);
		issue(16'h0000, 16'h8000, 1'b0, 1'b0);

		// Power-of-two divisors are exact
		op_a = random_operand();
		issue(op_a, 16'h4000, 1'b0, 1'b0);
		issue(op_a, 16'hc000, 1'b0, 1'b0);
		for (int i = 0; i < N_EXACT; i++) begin
			op_a = random_operand();
			r    = next_random();
			s    = int'(r % 53) - 26;
			op_b = value_to_posit(r[31], s, 40'd0, 1'b0);
			issue(op_a, op_b, 1'b0, 1'b0);
		end

		for (int i = 0; i < N_SIGN; i++) begin
			op_a = random_operand();
			op_b = random_operand();
			issue(op_a, op_b, 1'b1, 1'b0);
			issue(-op_a, op_b, 1'b1, 1'b1);
		end

		for (int i = 0; i < N_GENERAL; i++)
			issue(random_operand(), random_operand(), 1'b1, 1'b0);

		// maxpos and minpos pairs saturate
		issue(16'h7fff, 16'h0001, 1'b0, 1'b0);
		issue(16'h0001, 16'h7fff, 1'b0, 1'b0);
		issue(16'h8001, 16'h0001, 1'b0, 1'b0);
		issue(16'h7fff, 16'hffff, 1'b0, 1'b0);
		issue(16'h0001, 16'h8001, 1'b0, 1'b0);
		issue(16'hffff, 16'h7fff, 1'b0, 1'b0);

		idle();
		while (exp_q.size() != 0) @(posedge clk);
		repeat (2) @(posedge clk);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: posit_div.f
+incdir+include
src/posit_div_pkg.sv
src/posit_div_decode.sv
src/posit_div_nr_stage.sv
src/posit_div_pack.sv
src/posit_div_top.sv
dv/posit_div_properties.sv
dv/posit_div_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the posit divider testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
	--top-module posit_div_tb \
	-f posit_div.f \
	-o posit_div_sim

out=$(./obj_dir/posit_div_sim || true)
echo "$out"
echo "$out" | grep -qx "Simulation PASSED"
